/* cfu_pkg.sv */
/*
 * cfu package
 * opcodes, buffer geometry, lane count and operand types shared
 * by the command controller, the operand buffers and the matmul engine
 */
package cfu_pkg;

  // operand buffer geometry
  localparam int BUF_ADDR_BITS = 10;
  localparam int BUF_DEPTH = 1 << BUF_ADDR_BITS;

  // byte lanes per B word, also the number of MAC cells
  localparam int LANES = 4;

  // buffer index, also carries K
  typedef logic [BUF_ADDR_BITS-1:0] buf_addr_t;

  // signed operand byte
  typedef logic signed [7:0] op_byte_t;

  // lane 0 sits in bits 31:24
  typedef op_byte_t [0:LANES-1] op_word_t;

  // accumulator, wraps on overflow
  typedef logic signed [31:0] acc_t;

  // result lane select for a read
  typedef logic [1:0] lane_sel_t;

  // function id bits 9:3
  typedef enum logic [6:0] {
    OP_WRITE_A = 7'd1,
    OP_WRITE_B = 7'd2,
    OP_COMPUTE = 7'd3,
    OP_READ    = 7'd4
  } cfu_op_e;

endpackage

/* operand_buffer.sv */
`timescale 1ns/1ps
/*
 * operand buffer
 * single-port synchronous RAM, one-cycle read, payload type set by parameter
 */
module operand_buffer
  import cfu_pkg::*;
#(
  parameter type payload_t = op_byte_t
) (
  input  logic      clk,
  input  logic      wr_en,
  input  buf_addr_t index,
  input  payload_t  wr_data,
  output payload_t  rd_data
);

  payload_t mem [BUF_DEPTH];

  // write port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[index] <= wr_data;
    end
  end

  // registered read, returns the old entry on a write to the same index
  always_ff @(posedge clk) begin
    rd_data <= mem[index];
  end

endmodule

/* mac_cell.sv */
`timescale 1ns/1ps
/*
 * multiply-accumulate cell
 * accumulates north times west, forwards west eastward through a register
 */
module mac_cell
  import cfu_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     clear,
  input  op_byte_t west,
  input  op_byte_t north,
  output op_byte_t east,
  output acc_t     acc
);

  acc_t     acc_q;
  acc_t     product;
  op_byte_t east_q;

  // both operands signed, so the product sign-extends to 32 bits
  assign product = north * west;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q  <= '0;
      east_q <= '0;
    end else begin
      east_q <= west;
      if (clear) begin
        acc_q <= '0;
      end else begin
        acc_q <= acc_q + product;
      end
    end
  end

  assign east = east_q;
  assign acc  = acc_q;

endmodule

/* pe_row.sv */
`timescale 1ns/1ps
/*
 * systolic PE row
 * a chain of MAC cells fed by A from the west and skewed B lanes from the north
 */
module pe_row
  import cfu_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     clear,
  input  op_byte_t a_in,
  input  op_word_t b_in,
  output acc_t     acc [LANES]
);

  // west operand as it moves east, one register per cell
  op_byte_t west_chain [LANES+1];

  assign west_chain[0] = a_in;

  for (genvar j = 0; j < LANES; j++) begin : g_lane
    op_byte_t north_lane;

    if (j == 0) begin : g_direct
      assign north_lane = b_in[j];
    end else begin : g_skew
      // lane j waits j cycles to meet A at cell j
      op_byte_t skew_q [j];

      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          skew_q <= '{default: '0};
        end else begin
          skew_q[0] <= b_in[j];
          for (int i = 1; i < j; i++) begin
            skew_q[i] <= skew_q[i-1];
          end
        end
      end

      assign north_lane = skew_q[j-1];
    end

    mac_cell u_cell (
      .clk   (clk),
      .rst_n (rst_n),
      .clear (clear),
      .west  (west_chain[j]),
      .north (north_lane),
      .east  (west_chain[j+1]),
      .acc   (acc[j])
    );
  end

  // clear lands only between passes, never on live A data
  a_clear_idle: assert property (@(posedge clk) disable iff (!rst_n)
    clear |-> (a_in == '0));

endmodule

/* matmul_engine.sv */
`timescale 1ns/1ps
/*
 * matmul engine
 * streams K entries of A and B through the PE row, waits for the
 * skewed lanes to drain and latches the result row
 */
module matmul_engine
  import cfu_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      start,
  input  buf_addr_t k_len,
  output buf_addr_t a_addr,
  output buf_addr_t b_addr,
  input  op_byte_t  a_rd_data,
  input  op_word_t  b_rd_data,
  output logic      busy,
  output logic      done,
  output acc_t      result [LANES]
);

  // one bit wider than K so the drain count fits
  logic [BUF_ADDR_BITS:0] cnt_q;
  buf_addr_t              k_q;
  logic                   busy_q;
  logic                   done_q;
  logic                   rd_valid_q;
  logic                   rd_active;
  logic                   drain_end;
  op_byte_t               a_gated;
  op_word_t               b_gated;
  acc_t                   row_acc [LANES];
  acc_t                   result_q [LANES];

  // reads go out while the count is below K
  assign rd_active = busy_q && (cnt_q < {1'b0, k_q});

  // last product reaches the east cell LANES cycles after the last read
  assign drain_end = busy_q &&
    (cnt_q == ({1'b0, k_q} + (BUF_ADDR_BITS+1)'(LANES)));

  assign a_addr = cnt_q[BUF_ADDR_BITS-1:0];
  assign b_addr = cnt_q[BUF_ADDR_BITS-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
      rd_valid_q <= 1'b0;
      cnt_q      <= '0;
      k_q        <= '0;
    end else begin
      done_q     <= drain_end;
      rd_valid_q <= rd_active;
      if (start) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
        k_q    <= k_len;
      end else if (drain_end) begin
        busy_q <= 1'b0;
      end else if (busy_q) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // RAM data is valid one cycle behind the read window
  assign a_gated = rd_valid_q ? a_rd_data : '0;
  assign b_gated = rd_valid_q ? b_rd_data : '0;

  pe_row u_row (
    .clk   (clk),
    .rst_n (rst_n),
    .clear (start),
    .a_in  (a_gated),
    .b_in  (b_gated),
    .acc   (row_acc)
  );

  // result row holds until the next compute finishes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_q <= '{default: '0};
    end else if (drain_end) begin
      result_q <= row_acc;
    end
  end

  assign busy   = busy_q;
  assign done   = done_q;
  assign result = result_q;

  a_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
    start |-> !busy_q);

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    done_q |=> !done_q);

endmodule

/* cfu_cmd_ctrl.sv */
`timescale 1ns/1ps
/*
 * cfu command controller
 * decodes CPU commands, writes the operand buffers, launches the engine
 * and returns one response per command over a valid/ready pair
 */
module cfu_cmd_ctrl
  import cfu_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cmd_valid,
  output logic        cmd_ready,
  input  logic [9:0]  cmd_function_id,
  input  logic [31:0] cmd_inputs_0,
  input  logic [31:0] cmd_inputs_1,
  output logic        rsp_valid,
  input  logic        rsp_ready,
  output logic [31:0] rsp_outputs_0,
  output logic        a_wr_en,
  output buf_addr_t   a_index,
  output op_byte_t    a_wr_data,
  output logic        b_wr_en,
  output buf_addr_t   b_index,
  output op_word_t    b_wr_data,
  input  buf_addr_t   eng_a_addr,
  input  buf_addr_t   eng_b_addr,
  output logic        eng_start,
  output buf_addr_t   eng_k_len,
  input  logic        eng_done,
  input  acc_t        result [LANES]
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_EXECUTE,
    ST_COMPUTE,
    ST_RESPOND
  } state_e;

  state_e      state_q;
  logic [9:0]  func_q;
  logic [31:0] in0_q;
  logic [31:0] in1_q;
  cfu_op_e     op;
  lane_sel_t   lane;
  logic        cmd_fire;
  logic        rsp_fire;
  logic        rsp_valid_q;
  logic [31:0] rsp_data_q;

  assign cmd_ready = (state_q == ST_IDLE);
  assign cmd_fire  = cmd_valid && cmd_ready;
  assign rsp_fire  = rsp_valid_q && rsp_ready;
  assign op        = cfu_op_e'(func_q[9:3]);
  assign lane      = in1_q[1:0];

  // command payload, captured at transfer
  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      func_q <= cmd_function_id;
      in0_q  <= cmd_inputs_0;
      in1_q  <= cmd_inputs_1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE:    if (cmd_fire) state_q <= ST_EXECUTE;
        ST_EXECUTE: state_q <= (op == OP_COMPUTE) ? ST_COMPUTE : ST_RESPOND;
        ST_COMPUTE: if (eng_done) state_q <= ST_RESPOND;
        ST_RESPOND: if (rsp_fire) state_q <= ST_IDLE;
        default:    state_q <= ST_IDLE;
      endcase
    end
  end

  // compute raises valid with done, the other commands one cycle into respond
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid_q <= 1'b0;
      rsp_data_q  <= '0;
    end else if (rsp_fire) begin
      rsp_valid_q <= 1'b0;
    end else if (state_q == ST_COMPUTE && eng_done) begin
      rsp_valid_q <= 1'b1;
      rsp_data_q  <= '0;
    end else if (state_q == ST_RESPOND && !rsp_valid_q) begin
      rsp_valid_q <= 1'b1;
      rsp_data_q  <= (op == OP_READ) ? result[lane] : '0;
    end
  end

  // single-cycle buffer writes
  assign a_wr_en   = (state_q == ST_EXECUTE) && (op == OP_WRITE_A);
  assign b_wr_en   = (state_q == ST_EXECUTE) && (op == OP_WRITE_B);
  assign a_wr_data = in1_q[31:24];
  assign b_wr_data = in1_q;

  // engine owns the buffer indices during compute
  assign a_index = (state_q == ST_COMPUTE) ? eng_a_addr : in0_q[BUF_ADDR_BITS-1:0];
  assign b_index = (state_q == ST_COMPUTE) ? eng_b_addr : in0_q[BUF_ADDR_BITS-1:0];

  assign eng_start = (state_q == ST_EXECUTE) && (op == OP_COMPUTE);
  assign eng_k_len = in0_q[BUF_ADDR_BITS-1:0];

  assign rsp_valid     = rsp_valid_q;
  assign rsp_outputs_0 = rsp_data_q;

  a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_outputs_0)));

endmodule

/* cfu_top.sv */
`timescale 1ns/1ps
/*
 * cfu top
 * dot-product accelerator on the CPU command/response port
 */
module cfu_top
  import cfu_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cmd_valid,
  output logic        cmd_ready,
  input  logic [9:0]  cmd_function_id,
  input  logic [31:0] cmd_inputs_0,
  input  logic [31:0] cmd_inputs_1,
  output logic        rsp_valid,
  input  logic        rsp_ready,
  output logic [31:0] rsp_outputs_0
);

  logic      a_wr_en;
  buf_addr_t a_index;
  op_byte_t  a_wr_data;
  op_byte_t  a_rd_data;
  logic      b_wr_en;
  buf_addr_t b_index;
  op_word_t  b_wr_data;
  op_word_t  b_rd_data;
  buf_addr_t eng_a_addr;
  buf_addr_t eng_b_addr;
  logic      eng_start;
  buf_addr_t eng_k_len;
  logic      eng_done;
  acc_t      result [LANES];

  cfu_cmd_ctrl u_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .cmd_valid       (cmd_valid),
    .cmd_ready       (cmd_ready),
    .cmd_function_id (cmd_function_id),
    .cmd_inputs_0    (cmd_inputs_0),
    .cmd_inputs_1    (cmd_inputs_1),
    .rsp_valid       (rsp_valid),
    .rsp_ready       (rsp_ready),
    .rsp_outputs_0   (rsp_outputs_0),
    .a_wr_en         (a_wr_en),
    .a_index         (a_index),
    .a_wr_data       (a_wr_data),
    .b_wr_en         (b_wr_en),
    .b_index         (b_index),
    .b_wr_data       (b_wr_data),
    .eng_a_addr      (eng_a_addr),
    .eng_b_addr      (eng_b_addr),
    .eng_start       (eng_start),
    .eng_k_len       (eng_k_len),
    .eng_done        (eng_done),
    .result          (result)
  );

  // buffer A, one signed byte per entry
  operand_buffer #(.payload_t(op_byte_t)) u_buf_a (
    .clk     (clk),
    .wr_en   (a_wr_en),
    .index   (a_index),
    .wr_data (a_wr_data),
    .rd_data (a_rd_data)
  );

  // buffer B, four byte lanes per entry
  operand_buffer #(.payload_t(op_word_t)) u_buf_b (
    .clk     (clk),
    .wr_en   (b_wr_en),
    .index   (b_index),
    .wr_data (b_wr_data),
    .rd_data (b_rd_data)
  );

  // busy is only checked inside the engine
  matmul_engine u_engine (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (eng_start),
    .k_len     (eng_k_len),
    .a_addr    (eng_a_addr),
    .b_addr    (eng_b_addr),
    .a_rd_data (a_rd_data),
    .b_rd_data (b_rd_data),
    .busy      (),
    .done      (eng_done),
    .result    (result)
  );

endmodule

/* tb_cfu_model.svh */
/*
 * cfu testbench model
 * shadow copies of both operand buffers, the expected result row
 * and the compare tasks
 */
`ifndef TB_CFU_MODEL_SVH
`define TB_CFU_MODEL_SVH

  // mirrors of buffers A and B as the testbench wrote them
  op_byte_t    shadow_a [BUF_DEPTH];
  logic [31:0] shadow_b [BUF_DEPTH];
  acc_t        exp_row [LANES];
  int          err_cnt;
  int          check_cnt;

  // lane j is the sum of A[k] times byte j of B[k], byte 0 in bits 31:24
  function automatic void dot_row(input int k_len, output acc_t row [LANES]);
    int       sum;
    op_byte_t b_byte;
    for (int j = 0; j < LANES; j++) begin
      sum = 0;
      for (int k = 0; k < k_len; k++) begin
        b_byte = shadow_b[k][31-8*j -: 8];
        sum = sum + int'(shadow_a[k]) * int'(b_byte);
      end
      row[j] = acc_t'(sum);
    end
  endfunction

  task automatic check_lane(input acc_t got, input acc_t exp, input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail at %0t: %s returned %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_zero_rsp(input logic [31:0] got, input string what);
    check_cnt++;
    if (got !== 32'h0) begin
      err_cnt++;
      $display("Fail at %0t: %s returned %h, expected zero", $time, what, got);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

`endif

/* tb_cfu_top.sv */
`timescale 1ns/1ps
/*
 * cfu testbench
 * drives command sequences into the accelerator and checks every response
 */
module tb_cfu_top
  import cfu_pkg::*;
();

  localparam int WAIT_LIMIT = 2000;

  logic        clk;
  logic        rst_n;
  logic        cmd_valid;
  logic        cmd_ready;
  logic [9:0]  cmd_function_id;
  logic [31:0] cmd_inputs_0;
  logic [31:0] cmd_inputs_1;
  logic        rsp_valid;
  logic        rsp_ready;
  logic [31:0] rsp_outputs_0;
  logic        timed_out;
  int          hold_max;
  int          test_errs;
  int          tests_bad;

  `include "tb_cfu_model.svh"

  cfu_top cfu_top_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .cmd_valid       (cmd_valid),
    .cmd_ready       (cmd_ready),
    .cmd_function_id (cmd_function_id),
    .cmd_inputs_0    (cmd_inputs_0),
    .cmd_inputs_1    (cmd_inputs_1),
    .rsp_valid       (rsp_valid),
    .rsp_ready       (rsp_ready),
    .rsp_outputs_0   (rsp_outputs_0)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // one command, then a random spell of back-pressure before taking the response
  task automatic send_cmd(input logic [6:0] code, input logic [31:0] in0,
                          input logic [31:0] in1, output logic [31:0] rsp);
    int          waited;
    int          hold;
    logic [31:0] first;
    rsp = '0;
    if (timed_out) return;
    @(posedge clk);
    #2;
    cmd_valid       = 1'b1;
    cmd_function_id = {code, 3'b000};
    cmd_inputs_0    = in0;
    cmd_inputs_1    = in1;
    waited = 0;
    while (!cmd_ready && waited < WAIT_LIMIT) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (!cmd_ready) begin
      $display("timeout: cmd_ready stayed low for %0d cycles", WAIT_LIMIT);
      timed_out = 1'b1;
      err_cnt++;
      cmd_valid = 1'b0;
      return;
    end
    // transfer edge
    @(posedge clk);
    #2;
    cmd_valid = 1'b0;
    waited = 0;
    while (!rsp_valid && waited < WAIT_LIMIT) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (!rsp_valid) begin
      $display("timeout: no response within %0d cycles of the command", WAIT_LIMIT);
      timed_out = 1'b1;
      err_cnt++;
      return;
    end
    first = rsp_outputs_0;
    hold = $urandom_range(hold_max, 0);
    for (int i = 0; i < hold; i++) begin
      @(posedge clk);
      #2;
      check_flag(rsp_valid, 1'b1, "rsp_valid under back-pressure");
      check_flag(cmd_ready, 1'b0, "cmd_ready under back-pressure");
      check_lane(acc_t'(rsp_outputs_0), acc_t'(first), "held response");
    end
    rsp = rsp_outputs_0;
    rsp_ready = 1'b1;
    @(posedge clk);
    #2;
    rsp_ready = 1'b0;
  endtask

  task automatic write_a(input int idx, input op_byte_t data);
    logic [31:0] rsp;
    send_cmd(OP_WRITE_A, {22'($urandom), 10'(idx)}, {data, 24'($urandom)}, rsp);
    shadow_a[idx] = data;
    check_zero_rsp(rsp, "write A response");
  endtask

  task automatic write_b(input int idx, input logic [31:0] word);
    logic [31:0] rsp;
    send_cmd(OP_WRITE_B, {22'($urandom), 10'(idx)}, word, rsp);
    shadow_b[idx] = word;
    check_zero_rsp(rsp, "write B response");
  endtask

  task automatic run_compute(input int k);
    logic [31:0] rsp;
    send_cmd(OP_COMPUTE, {22'($urandom), 10'(k)}, $urandom, rsp);
    check_zero_rsp(rsp, "compute response");
    dot_row(k, exp_row);
  endtask

  // reads all four lanes, operand 0 is junk on purpose
  task automatic read_row();
    logic [31:0] rsp;
    for (int j = 0; j < LANES; j++) begin
      send_cmd(OP_READ, $urandom, {30'($urandom), 2'(j)}, rsp);
      check_lane(acc_t'(rsp), exp_row[j], $sformatf("read lane %0d", j));
    end
  endtask

  task automatic end_test(input int num, input string name);
    $display("test %0d %s: %0d errors", num, name, err_cnt - test_errs);
    if (err_cnt != test_errs) tests_bad++;
    test_errs = err_cnt;
  endtask

  initial begin
    logic [31:0] rsp;
    rst_n           = 1'b0;
    cmd_valid       = 1'b0;
    cmd_function_id = '0;
    cmd_inputs_0    = '0;
    cmd_inputs_1    = '0;
    rsp_ready       = 1'b0;
    timed_out       = 1'b0;
    hold_max        = 3;
    err_cnt         = 0;
    check_cnt       = 0;
    test_errs       = 0;
    tests_bad       = 0;
    exp_row         = '{default: '0};
    void'($urandom(32'h6c742e9d));
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    #2;

    check_flag(cmd_ready, 1'b1, "cmd_ready after reset");
    check_flag(rsp_valid, 1'b0, "rsp_valid after reset");
    read_row();
    end_test(1, "reset state");

    // bytes 5, -3, -128, 127 against a negative A
    write_a(0, op_byte_t'(-7));
    write_b(0, 32'h05fd807f);
    run_compute(1);
    read_row();
    end_test(2, "single product");

    for (int i = 0; i < 64; i++) begin
      write_a(i, op_byte_t'($urandom));
      write_b(i, $urandom);
    end
    run_compute(64);
    read_row();
    end_test(3, "random K=64");

    run_compute(0);
    read_row();
    run_compute(5);
    read_row();
    end_test(4, "K=0 then K=5");

    // long stalls on every response
    hold_max = 12;
    for (int i = 0; i < 8; i++) begin
      write_a(i, op_byte_t'($urandom));
      write_b(i, $urandom);
    end
    run_compute(8);
    read_row();
    hold_max = 3;
    end_test(5, "back-pressure");

    send_cmd(7'd7, $urandom, $urandom, rsp);
    check_zero_rsp(rsp, "unknown opcode response");
    read_row();
    end_test(6, "unknown opcode");

    $display("summary: 6 tests, %0d with errors, %0d checks, %0d mismatches",
             tests_bad, check_cnt, err_cnt);
    if (err_cnt == 0 && !timed_out) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+.
cfu_pkg.sv
operand_buffer.sv
mac_cell.sv
pe_row.sv
matmul_engine.sv
cfu_cmd_ctrl.sv
cfu_top.sv
tb_cfu_top.sv

/* Makefile */
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module tb_cfu_top -o sim_cfu
	./obj_dir/sim_cfu | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
